/* bench/tb_dram_subsystem.sv */
`timescale 1ns/1ps

module tb_dram_subsystem;
    import dram_pkg::*;

    localparam int WORDS        = 2 ** (ADDR_W - 2);
    localparam int N_STRB       = 10;
    localparam int N_LONG       = 12;
    localparam int N_STALL      = 8;
    localparam int N_MIXED      = 60;
    localparam int MAX_STALL    = 12;
    // worst case cycles per beat and per burst, stalls included
    localparam int BEAT_CYC     = T_PHASE + CAS_LAT + MAX_STALL + 4;
    localparam int BURST_CYC    = 3 * T_PHASE + 16 * BEAT_CYC + MAX_STALL + 8;
    localparam int N_BURSTS     = 2 + 3 * N_STRB + 2 * N_LONG + 2 * N_STALL + 2 + N_MIXED;
    localparam int WATCHDOG_CYC = N_BURSTS * BURST_CYC + 100;

    logic              clk;
    logic              rst;
    logic [ID_W-1:0]   awid;
    logic [ADDR_W-1:0] awaddr;
    logic [LEN_W-1:0]  awlen;
    logic [1:0]        awburst;
    logic [2:0]        awsize;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [3:0]        wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic [ID_W-1:0]   bid;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [ID_W-1:0]   arid;
    logic [ADDR_W-1:0] araddr;
    logic [LEN_W-1:0]  arlen;
    logic [1:0]        arburst;
    logic [2:0]        arsize;
    logic              arvalid;
    logic              arready;
    logic [ID_W-1:0]   rid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rlast;
    logic              rvalid;
    logic              rready;

    logic [31:0] seed;
    int          checks;
    int          errors;
    int          stall_max;
    string       test_name;

    // byte lanes of every word, plus which lanes hold a known value
    logic [7:0] ref_mem [WORDS][4];
    bit         known [WORDS][4];

    dram_subsystem dut (
        .clk       (clk),
        .rst       (rst),
        .awid_i    (awid),
        .awaddr_i  (awaddr),
        .awlen_i   (awlen),
        .awburst_i (awburst),
        .awsize_i  (awsize),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wlast_i   (wlast),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bid_o     (bid),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .arid_i    (arid),
        .araddr_i  (araddr),
        .arlen_i   (arlen),
        .arburst_i (arburst),
        .arsize_i  (arsize),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rid_o     (rid),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rlast_o   (rlast),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper bits, the low ones of an lcg repeat quickly
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic void check_val(input string what, input logic [31:0] exp,
                                      input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr(input logic [LEN_W-1:0] len);
        dram_addr_u a;
        a.f.row = ROW_W'(rand_below(2 ** ROW_W));
        a.f.col = COL_W'(rand_below(2 ** COL_W - int'(len)));
        a.f.off = 2'b00;
        return a.flat;
    endfunction

    // all tasks start and end on a falling edge
    task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                               input logic [LEN_W-1:0] len, input bit part_strb);
        int          word;
        int          stall;
        logic [31:0] data;
        logic [3:0]  strb;
        word    = int'(addr >> 2);
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awvalid = 1'b1;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            data = next_rand();
            strb = part_strb ? 4'(next_rand() >> 16) : 4'hf;
            // at least one lane enabled
            if (strb == 4'h0) strb = 4'h1;
            wdata  = data;
            wstrb  = strb;
            wlast  = i == int'(len);
            wvalid = 1'b1;
            #1;
            while (!wready) begin
                @(negedge clk);
                #1;
            end
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[word + i][b] = data[8*b +: 8];
                    known[word + i][b]   = 1'b1;
                end
            end
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        stall  = rand_below(stall_max + 1);
        #1;
        while (!bvalid) begin
            @(negedge clk);
            #1;
        end
        repeat (stall + 1) @(negedge clk);
        bready = 1'b1;
        #1;
        check_val("bid", 32'(id), 32'(bid));
        check_val("bresp", 32'd0, 32'(bresp));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input logic [LEN_W-1:0] len);
        int          word;
        int          stall;
        logic [31:0] exp;
        logic [31:0] mask;
        word    = int'(addr >> 2);
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            stall = rand_below(stall_max + 1);
            #1;
            while (!rvalid) begin
                @(negedge clk);
                #1;
            end
            repeat (stall + 1) @(negedge clk);
            rready = 1'b1;
            #1;
            for (int b = 0; b < 4; b++) begin
                exp[8*b +: 8]  = ref_mem[word + i][b];
                mask[8*b +: 8] = known[word + i][b] ? 8'hff : 8'h00;
            end
            check_val($sformatf("rdata beat %0d", i), exp & mask, rdata & mask);
            check_val("rlast", 32'(i == int'(len)), 32'(rlast));
            check_val("rid", 32'(id), 32'(rid));
            check_val("rresp", 32'd0, 32'(rresp));
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    a_r_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
        else begin
            errors++;
            $display("R channel changed while the master held rready low");
        end

    a_b_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid && !bready |=> bvalid && $stable(bid))
        else begin
            errors++;
            $display("B channel changed while the master held bready low");
        end

    a_write_first: assert property (@(posedge clk) disable iff (!rst)
        awvalid |-> !arready)
        else begin
            errors++;
            $display("arready was high while awvalid was pending");
        end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout, the bursts did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] wr_addr_q [$];
        logic [LEN_W-1:0]  wr_len_q [$];
        int                pick;
        seed      = 32'hede2add7;
        checks    = 0;
        errors    = 0;
        stall_max = 3;
        rst       = 1'b0;
        {awid, awaddr, awlen, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arvalid, rready} = '0;
        awburst = 2'b01;
        arburst = 2'b01;
        awsize  = 3'b010;
        arsize  = 3'b010;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_name = "reset and single beat";
        #1;
        check_val("awready", 32'd1, 32'(awready));
        check_val("arready", 32'd1, 32'(arready));
        check_val("rvalid", 32'd0, 32'(rvalid));
        check_val("bvalid", 32'd0, 32'(bvalid));
        check_val("wready", 32'd0, 32'(wready));
        @(negedge clk);
        write_burst(4'h3, 14'h0124, 4'd0, 1'b0);
        read_burst(4'h5, 14'h0124, 4'd0);

        test_name = "partial strobes";
        for (int n = 0; n < N_STRB; n++) begin
            addr = rand_addr(4'd0);
            write_burst(4'(n), addr, 4'd0, 1'b0);
            write_burst(4'(n + 1), addr, 4'd0, 1'b1);
            read_burst(4'(n + 2), addr, 4'd0);
        end

        test_name = "long bursts";
        for (int n = 0; n < N_LONG; n++) begin
            len  = 4'(rand_below(16));
            addr = rand_addr(len);
            write_burst(4'(next_rand() >> 16), addr, len, 1'b0);
            read_burst(4'(next_rand() >> 16), addr, len);
        end

        test_name = "ready stalls";
        stall_max = MAX_STALL;
        for (int n = 0; n < N_STALL; n++) begin
            len  = 4'(rand_below(16));
            addr = rand_addr(len);
            write_burst(4'(next_rand() >> 16), addr, len, 1'b1);
            read_burst(4'(next_rand() >> 16), addr, len);
        end
        stall_max = 3;

        test_name = "aw and ar together";
        len  = 4'd3;
        addr = rand_addr(len);
        fork
            write_burst(4'h9, addr, len, 1'b0);
            begin
                arid    = 4'ha;
                araddr  = addr;
                arlen   = len;
                arvalid = 1'b1;
            end
        join
        read_burst(4'ha, addr, len);

        test_name = "mixed traffic";
        for (int n = 0; n < N_MIXED; n++) begin
            if (rand_below(2) == 0 || wr_addr_q.size() == 0) begin
                len  = 4'(rand_below(16));
                addr = rand_addr(len);
                write_burst(4'(next_rand() >> 16), addr, len, rand_below(2) == 1);
                wr_addr_q.push_back(addr);
                wr_len_q.push_back(len);
            end else begin
                pick = rand_below(wr_addr_q.size());
                read_burst(4'(next_rand() >> 16), wr_addr_q[pick], wr_len_q[pick]);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/axi_dram_frontend.sv */
`timescale 1ns/1ps

module axi_dram_frontend (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [dram_pkg::ID_W-1:0]   awid_i,
    input  logic [dram_pkg::ADDR_W-1:0] awaddr_i,
    input  logic [dram_pkg::LEN_W-1:0]  awlen_i,
    input  logic [1:0]                  awburst_i,
    input  logic [2:0]                  awsize_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic [dram_pkg::DATA_W-1:0] wdata_i,
    input  logic [dram_pkg::STRB_W-1:0] wstrb_i,
    input  logic                        wlast_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output logic [dram_pkg::ID_W-1:0]   bid_o,
    output logic [1:0]                  bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  logic [dram_pkg::ID_W-1:0]   arid_i,
    input  logic [dram_pkg::ADDR_W-1:0] araddr_i,
    input  logic [dram_pkg::LEN_W-1:0]  arlen_i,
    input  logic [1:0]                  arburst_i,
    input  logic [2:0]                  arsize_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output logic [dram_pkg::ID_W-1:0]   rid_o,
    output logic [dram_pkg::DATA_W-1:0] rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rlast_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    dram_req_if.front                   req
);
    import dram_pkg::*;

    enum logic [1:0] {FE_IDLE, FE_WRITE, FE_READ, FE_RESP} state;

    dram_addr_u       aw_addr;
    dram_addr_u       ar_addr;
    logic             aw_hs;
    logic             ar_hs;
    logic             w_hs;
    logic             r_hs;
    logic [ID_W-1:0]  id_q;
    logic [LEN_W-1:0] rbeat;
    logic [LEN_W-1:0] wbeat;

    assign aw_addr.flat = awaddr_i;
    assign ar_addr.flat = araddr_i;

    // writes win, so AR waits while AW is pending
    assign awready_o = state == FE_IDLE;
    assign arready_o = (state == FE_IDLE) && !awvalid_i;
    assign wready_o  = (state == FE_WRITE) && req.beat_rdy;

    assign aw_hs = awvalid_i && awready_o;
    assign ar_hs = arvalid_i && arready_o;
    assign w_hs  = wvalid_i && wready_o;
    assign r_hs  = rvalid_o && rready_i;

    assign req.beat_go = w_hs || r_hs;
    assign req.wdata   = wdata_i;
    assign req.wstrb   = wstrb_i;

    assign bid_o    = id_q;
    assign bresp_o  = 2'b00;
    assign bvalid_o = state == FE_RESP;
    assign rid_o    = id_q;
    assign rresp_o  = 2'b00;
    assign rlast_o  = rbeat == req.len;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= FE_IDLE;
            req.start <= 1'b0;
            rvalid_o  <= 1'b0;
            rbeat     <= '0;
            wbeat     <= '0;
        end else begin
            req.start <= aw_hs || ar_hs;
            case (state)
                FE_IDLE: begin
                    if (aw_hs) begin
                        state <= FE_WRITE;
                    end else if (ar_hs) begin
                        state <= FE_READ;
                    end
                end
                FE_WRITE: if (req.done) state <= FE_RESP;
                FE_READ:  if (req.done) state <= FE_IDLE;
                FE_RESP:  if (bready_i) state <= FE_IDLE;
                default:  state <= FE_IDLE;
            endcase
            // word held until the master takes it
            if (req.rd_valid) begin
                rvalid_o <= 1'b1;
            end else if (r_hs) begin
                rvalid_o <= 1'b0;
            end
            if (ar_hs) begin
                rbeat <= '0;
            end else if (r_hs) begin
                rbeat <= rbeat + 1'b1;
            end
            if (aw_hs) begin
                wbeat <= '0;
            end else if (w_hs) begin
                wbeat <= wbeat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q      <= awid_i;
            req.row   <= aw_addr.f.row;
            req.col   <= aw_addr.f.col;
            req.len   <= awlen_i;
            req.write <= 1'b1;
        end else if (ar_hs) begin
            id_q      <= arid_i;
            req.row   <= ar_addr.f.row;
            req.col   <= ar_addr.f.col;
            req.len   <= arlen_i;
            req.write <= 1'b0;
        end
        if (req.rd_valid) begin
            rdata_o <= req.rd_data;
        end
    end

    // full width beats, no reserved burst type
    a_aw_shape: assert property (@(posedge clk) disable iff (!rst)
        aw_hs |-> awsize_i == 3'($clog2(STRB_W)) && awburst_i != 2'b11);
    a_ar_shape: assert property (@(posedge clk) disable iff (!rst)
        ar_hs |-> arsize_i == 3'($clog2(STRB_W)) && arburst_i != 2'b11);

    a_wlast: assert property (@(posedge clk) disable iff (!rst)
        w_hs |-> wlast_i == (wbeat == req.len));

endmodule

/* hdl/dram_bus_if.sv */
`timescale 1ns/1ps

interface dram_bus_if;
    import dram_pkg::*;

    logic                csn;
    logic                rasn;
    logic                casn;
    // active low byte write enables
    logic [STRB_W-1:0]   wen;
    logic [DRAM_A_W-1:0] a;
    logic [DATA_W-1:0]   d;
    logic [DATA_W-1:0]   q;
    logic                q_valid;

    modport ctrl (
        output csn, rasn, casn, wen, a, d,
        input  q, q_valid
    );

    modport device (
        input  csn, rasn, casn, wen, a, d,
        output q, q_valid
    );

endinterface

/* hdl/dram_device.sv */
`timescale 1ns/1ps

module dram_device (
    input  logic       clk,
    input  logic       rst,
    dram_bus_if.device bus
);
    import dram_pkg::*;

    logic [DATA_W-1:0]      mem [2 ** (ROW_W + COL_W)];
    logic [DATA_W-1:0]      q_pipe [CAS_LAT];
    logic [CAS_LAT-1:0]     v_pipe;
    logic [ROW_W-1:0]       open_row;
    logic                   row_open;
    logic [ROW_W+COL_W-1:0] idx;
    logic                   ras;
    logic                   cas;
    logic                   wr;

    assign ras = !bus.csn && !bus.rasn;
    assign cas = !bus.csn && !bus.casn;
    assign wr  = !(&bus.wen);
    assign idx = {open_row, bus.a[COL_W-1:0]};

    assign bus.q       = q_pipe[CAS_LAT-1];
    assign bus.q_valid = v_pipe[CAS_LAT-1];

    // RAS with enables high opens a row, with enables low closes it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            row_open <= 1'b0;
            v_pipe   <= '0;
        end else begin
            if (ras) row_open <= !wr;
            v_pipe <= (v_pipe << 1) | CAS_LAT'(cas && !wr);
        end
    end

    always_ff @(posedge clk) begin
        if (ras && !wr) open_row <= bus.a[ROW_W-1:0];
        if (cas && wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (!bus.wen[b]) mem[idx][8*b +: 8] <= bus.d[8*b +: 8];
            end
        end
        if (cas && !wr) q_pipe[0] <= mem[idx];
        for (int s = 1; s < CAS_LAT; s++) begin
            q_pipe[s] <= q_pipe[s-1];
        end
    end

    a_cas_open: assert property (@(posedge clk) disable iff (!rst)
        cas |-> row_open);

endmodule

/* hdl/dram_pkg.sv */
package dram_pkg;

    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int ID_W     = 4;
    localparam int LEN_W    = 4;

    // dram geometry, one row holds 2**COL_W words
    localparam int ROW_W    = 6;
    localparam int COL_W    = 6;
    localparam int ADDR_W   = ROW_W + COL_W + 2;
    localparam int DRAM_A_W = (ROW_W > COL_W) ? ROW_W : COL_W;

    // cycles per activate, column or precharge phase
    localparam int T_PHASE  = 5;
    // read CAS to data valid
    localparam int CAS_LAT  = 2;
    localparam int CNT_W    = $clog2(T_PHASE);

    // axi byte address, seen whole or split for the row/column mux
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [ROW_W-1:0] row;
            logic [COL_W-1:0] col;
            logic [1:0]       off;
        } f;
    } dram_addr_u;

endpackage

/* hdl/dram_req_if.sv */
`timescale 1ns/1ps

interface dram_req_if;
    import dram_pkg::*;

    // transaction, valid with start
    logic              start;
    logic              write;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
    logic [LEN_W-1:0]  len;

    // per beat traffic
    logic              beat_go;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              beat_rdy;
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;
    logic              done;

    modport front (
        output start, write, row, col, len, beat_go, wdata, wstrb,
        input  beat_rdy, rd_valid, rd_data, done
    );

    modport seq (
        input  start, write, row, col, len, beat_go, wdata, wstrb,
        output beat_rdy, rd_valid, rd_data, done
    );

endinterface

/* hdl/dram_sequencer.sv */
`timescale 1ns/1ps

module dram_sequencer (
    input  logic     clk,
    input  logic     rst,
    dram_req_if.seq  req,
    dram_bus_if.ctrl bus
);
    import dram_pkg::*;

    enum logic [2:0] {S_IDLE, S_ACT, S_RCOL, S_WCOL, S_PRE} state;

    logic [CNT_W-1:0]  cnt;
    logic              phase_end;
    logic              run;
    logic              rd_wait;
    logic              taken;
    logic              strobe;
    logic              col_phase;
    logic              beat_adv;
    logic              last_beat;
    logic [LEN_W-1:0]  beat;
    logic [LEN_W-1:0]  len_q;
    logic              write_q;
    logic [ROW_W-1:0]  row_q;
    logic [COL_W-1:0]  col_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;

    assign phase_end = cnt == CNT_W'(T_PHASE - 1);
    assign col_phase = (state == S_RCOL) || (state == S_WCOL);
    assign last_beat = beat == len_q;

    // a write beat only runs its phase once data is in
    assign strobe = (cnt == '0) && (state != S_IDLE) && (state != S_WCOL || run);

    // read beat ends when the phase is over and the word was taken
    assign beat_adv = (state == S_RCOL && phase_end && (taken || req.beat_go)) ||
                      (state == S_WCOL && run && phase_end);

    assign req.beat_rdy = (state == S_RCOL) ? rd_wait : (state == S_WCOL && !run);
    assign req.done     = (state == S_PRE) && phase_end;
    assign req.rd_valid = bus.q_valid;
    assign req.rd_data  = bus.q;

    assign bus.csn  = state == S_IDLE;
    assign bus.rasn = !(strobe && (state == S_ACT || state == S_PRE));
    assign bus.casn = !(strobe && col_phase);
    assign bus.a    = col_phase ? DRAM_A_W'(col_q) : DRAM_A_W'(row_q);
    assign bus.d    = wdata_q;

    // precharge is RAS with all write enables low
    always_comb begin
        if (strobe && state == S_WCOL) begin
            bus.wen = ~wstrb_q;
        end else if (strobe && state == S_PRE) begin
            bus.wen = '0;
        end else begin
            bus.wen = '1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            run     <= 1'b0;
            rd_wait <= 1'b0;
            taken   <= 1'b0;
            beat    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt  <= '0;
                    beat <= '0;
                    if (req.start) state <= S_ACT;
                end
                S_ACT: begin
                    cnt <= phase_end ? '0 : cnt + 1'b1;
                    run <= 1'b0;
                    if (phase_end) state <= write_q ? S_WCOL : S_RCOL;
                end
                S_RCOL: begin
                    if (!phase_end) cnt <= cnt + 1'b1;
                    if (bus.q_valid) begin
                        rd_wait <= 1'b1;
                    end else if (req.beat_go) begin
                        rd_wait <= 1'b0;
                    end
                    if (req.beat_go) taken <= 1'b1;
                    if (beat_adv) begin
                        cnt   <= '0;
                        taken <= 1'b0;
                    end
                end
                S_WCOL: begin
                    if (!run) begin
                        if (req.beat_go) run <= 1'b1;
                    end else if (phase_end) begin
                        run <= 1'b0;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_PRE: begin
                    cnt <= phase_end ? '0 : cnt + 1'b1;
                    if (phase_end) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
            if (beat_adv) begin
                if (last_beat) begin
                    state <= S_PRE;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req.start) begin
            row_q   <= req.row;
            col_q   <= req.col;
            len_q   <= req.len;
            write_q <= req.write;
        end else if (beat_adv) begin
            col_q <= col_q + 1'b1;
        end
        if (state == S_WCOL && req.beat_go) begin
            wdata_q <= req.wdata;
            wstrb_q <= req.wstrb;
        end
    end

    // start only reaches an idle sequencer
    a_start_idle: assert property (@(posedge clk) disable iff (!rst)
        req.start |-> state == S_IDLE);

    // beat traffic only while a beat is wanted
    a_beat_rdy: assert property (@(posedge clk) disable iff (!rst)
        req.beat_go |-> req.beat_rdy);

    // bursts stay inside the opened row
    a_one_row: assert property (@(posedge clk) disable iff (!rst)
        (state == S_IDLE && req.start) |->
            ({1'b0, req.col} + (COL_W + 1)'(req.len)) <= (COL_W + 1)'(2 ** COL_W - 1));

endmodule

/* hdl/dram_subsystem.sv */
`timescale 1ns/1ps

module dram_subsystem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [dram_pkg::ID_W-1:0]   awid_i,
    input  logic [dram_pkg::ADDR_W-1:0] awaddr_i,
    input  logic [dram_pkg::LEN_W-1:0]  awlen_i,
    input  logic [1:0]                  awburst_i,
    input  logic [2:0]                  awsize_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic [dram_pkg::DATA_W-1:0] wdata_i,
    input  logic [dram_pkg::STRB_W-1:0] wstrb_i,
    input  logic                        wlast_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output logic [dram_pkg::ID_W-1:0]   bid_o,
    output logic [1:0]                  bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  logic [dram_pkg::ID_W-1:0]   arid_i,
    input  logic [dram_pkg::ADDR_W-1:0] araddr_i,
    input  logic [dram_pkg::LEN_W-1:0]  arlen_i,
    input  logic [1:0]                  arburst_i,
    input  logic [2:0]                  arsize_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output logic [dram_pkg::ID_W-1:0]   rid_o,
    output logic [dram_pkg::DATA_W-1:0] rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rlast_o,
    output logic                        rvalid_o,
    input  logic                        rready_i
);
    import dram_pkg::*;

    dram_req_if req_if ();
    dram_bus_if bus_if ();

    // axi port names match the front end one to one
    axi_dram_frontend u_front (
        .*,
        .req (req_if)
    );

    dram_sequencer u_seq (
        .clk (clk),
        .rst (rst),
        .req (req_if),
        .bus (bus_if)
    );

    dram_device u_dram (
        .clk (clk),
        .rst (rst),
        .bus (bus_if)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run with verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dram_subsystem \
    -f src.f -o tb_sim > sim.log 2>&1 &&
    ./obj_dir/tb_sim >> sim.log 2>&1 ||
    echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* src.f */
hdl/dram_pkg.sv
hdl/dram_bus_if.sv
hdl/dram_req_if.sv
hdl/axi_dram_frontend.sv
hdl/dram_sequencer.sv
hdl/dram_device.sv
hdl/dram_subsystem.sv
bench/tb_dram_subsystem.sv
